// File: Bender.yml
package:
  name: core_mem_port

sources:
  - include_dirs:
      - hw
    files:
      - hw/mem_qos_pkg.sv
      - hw/mem_qos_policy.sv
      - hw/mem_req_arbiter.sv
      - hw/mem_rsp_router.sv
      - hw/core_mem_port.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/tb_core_mem_port.sv

// File: bench/tb_core_mem_port.sv
// Testbench for core memory port arbitration, QoS tags and response routing
// plus the violation counter, with per-test reporting and a cycle timeout
`timescale 1ns/1ps
`default_nettype none

`include "mem_qos_macros.svh"

module tb_core_mem_port
    import mem_qos_pkg::*;
;

    localparam logic [3:0]  CORE_ID    = 4'd5;
    localparam int unsigned SEED       = 32'h1e7975e9;
    // 10 reset cycles plus about 40 per test for six tests
    localparam int unsigned MAX_CYCLES = 300;

    logic clk_i, rst_ni, qos_enable_i, exception_pending_i;
    qos_tag_t base_qos_i;
    logic fetch_req_valid_i, data_req_valid_i, data_req_write_i, mem_req_ready_i;
    logic [`MEM_ADDR_W-1:0] fetch_req_addr_i, data_req_addr_i;
    logic [`MEM_STRB_W-1:0] data_req_strb_i;
    logic [`MEM_DATA_W-1:0] data_req_wdata_i;
    logic mem_rsp_valid_i, fetch_rsp_ready_i, data_rsp_ready_i;
    mem_rsp_t mem_rsp_i;
    logic fetch_req_ready_o, data_req_ready_o, mem_req_valid_o, mem_rsp_ready_o;
    logic fetch_rsp_valid_o, data_rsp_valid_o;
    mem_req_t mem_req_o;
    qos_tag_t mem_qos_o;
    mem_rsp_t fetch_rsp_o, data_rsp_o;
    logic [`QOS_VIOL_W-1:0] qos_violations_o;

    string       test_name;
    int unsigned test_errs, tests_passed, tests_failed, cycle_cnt;
    int unsigned seed;
    logic [31:0] rnd;

    core_mem_port #(.CORE_ID(CORE_ID)) DUT (.*);

    // ------------------------------
    // Clock and timeout
    // ------------------------------
    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    // ------------------------------
    // Reference model from the tag rules
    // ------------------------------
    function automatic qos_tag_t exp_fetch_tag(input logic exc);
        qos_tag_t t;
        t = '0;
        t.fetch_not_data = 1'b1;
        t.guaranteed_bw  = 1'b1;
        t.core_id        = CORE_ID;
        t.level       = exc ? `QOS_LEVEL_CRITICAL : `QOS_LEVEL_HIGH;
        t.weight      = exc ? `QOS_WEIGHT_CRITICAL : `QOS_WEIGHT_HIGH;
        t.max_latency = exc ? `QOS_LAT_FETCH_CRIT : `QOS_LAT_FETCH_NORM;
        t.urgent      = exc;
        t.real_time   = exc;
        t.preemptable = !exc;
        return t;
    endfunction

    function automatic qos_tag_t exp_data_tag(input logic exc, input logic wr);
        qos_tag_t t;
        t = '0;
        t.core_id       = CORE_ID;
        t.urgent        = exc;
        t.real_time     = exc;
        t.preemptable   = !exc;
        t.guaranteed_bw = exc;
        if (exc) begin
            t.level       = `QOS_LEVEL_CRITICAL;
            t.weight      = `QOS_WEIGHT_CRITICAL;
            t.max_latency = `QOS_LAT_DATA_CRIT;
        end else begin
            // Stores rank below loads
            t.level       = wr ? `QOS_LEVEL_MEDIUM : `QOS_LEVEL_MEDIUM_HIGH;
            t.weight      = wr ? `QOS_WEIGHT_MEDIUM : `QOS_WEIGHT_MEDIUM_HIGH;
            t.max_latency = wr ? `QOS_LAT_STORE_NORM : `QOS_LAT_LOAD_NORM;
        end
        return t;
    endfunction

    function automatic mem_req_t fetch_beat();
        return '{addr: fetch_req_addr_i, write: 1'b0, strb: `MEM_STRB_FULL,
                 wdata: '0, id: `MEM_ID_FETCH, burst_len: '0};
    endfunction

    function automatic mem_req_t data_beat();
        return '{addr: data_req_addr_i, write: data_req_write_i, strb: data_req_strb_i,
                 wdata: data_req_wdata_i, id: `MEM_ID_DATA, burst_len: '0};
    endfunction

    // ------------------------------
    // Stimulus and check helpers
    // ------------------------------
    task automatic check(input string what, input logic [127:0] exp, input logic [127:0] act);
        assert (exp === act) else begin
            $display("ERR %s %s: expected %0h, actual %0h", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            tests_passed++;
            $display("%s: PASS", test_name);
        end else begin
            tests_failed++;
            $display("%s: FAIL with %0d errors", test_name, test_errs);
        end
    endtask

    // Drive point 1 ns after the rising edge
    task automatic drive_point();
        @(posedge clk_i);
        #1;
    endtask

    // Sample at the falling edge once outputs settle
    task automatic sample_point();
        @(negedge clk_i);
    endtask

    task automatic idle_inputs();
        fetch_req_valid_i = 1'b0;
        data_req_valid_i  = 1'b0;
        mem_rsp_valid_i   = 1'b0;
        mem_req_ready_i   = 1'b1;
    endtask

    task automatic random_payloads();
        fetch_req_addr_i = $urandom;
        data_req_addr_i  = $urandom;
        data_req_wdata_i = $urandom;
        rnd              = $urandom;
        data_req_strb_i  = rnd[3:0];
        data_req_write_i = rnd[4];
        mem_req_ready_i  = rnd[5];
        base_qos_i       = rnd[31:8];
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        logic [31:0] base_cnt;
        int unsigned n;
        seed = SEED;
        rnd  = $urandom(seed);
        cycle_cnt = 0;
        tests_passed = 0;
        tests_failed = 0;
        rst_ni = 1'b0;
        qos_enable_i = 1'b1;
        exception_pending_i = 1'b0;
        base_qos_i = '0;
        fetch_req_addr_i = '0;
        data_req_addr_i = '0;
        data_req_write_i = 1'b0;
        data_req_strb_i = '0;
        data_req_wdata_i = '0;
        mem_rsp_i = '0;
        fetch_rsp_ready_i = 1'b0;
        data_rsp_ready_i = 1'b0;
        idle_inputs();
        repeat (10) @(posedge clk_i);
        #1 rst_ni = 1'b1;

        // Counter first while the reset value is untouched
        start_test("violations");
        sample_point();
        check("count after reset", 0, qos_violations_o);
        for (int mode = 1; mode >= 0; mode--) begin
            base_cnt = qos_violations_o;
            n = $urandom_range(8, 1);
            drive_point();
            qos_enable_i = mode[0];
            fetch_req_valid_i = 1'b1;
            mem_req_ready_i = 1'b0;
            repeat (n) drive_point();
            idle_inputs();
            qos_enable_i = 1'b1;
            sample_point();
            check("count", mode[0] ? base_cnt + n : base_cnt, qos_violations_o);
        end
        end_test();

        start_test("data_alone");
        for (int i = 0; i < 6; i++) begin
            drive_point();
            random_payloads();
            data_req_valid_i = 1'b1;
            sample_point();
            check("valid", 1, mem_req_valid_o);
            check("req", data_beat(), mem_req_o);
            check("tag", exp_data_tag(1'b0, data_req_write_i), mem_qos_o);
            check("data ready", mem_req_ready_i, data_req_ready_o);
            check("fetch ready", 0, fetch_req_ready_o);
        end
        end_test();

        start_test("conflict");
        for (int i = 0; i < 6; i++) begin
            drive_point();
            random_payloads();
            exception_pending_i = i[0];
            fetch_req_valid_i = 1'b1;
            data_req_valid_i = 1'b1;
            sample_point();
            // Exception lifts data above fetch
            if (exception_pending_i) begin
                check("req", data_beat(), mem_req_o);
                check("tag", exp_data_tag(1'b1, data_req_write_i), mem_qos_o);
                check("data ready", mem_req_ready_i, data_req_ready_o);
                check("fetch ready", 0, fetch_req_ready_o);
                check("fetch tag", exp_fetch_tag(1'b1), DUT.fetch_tag);
            end else begin
                check("req", fetch_beat(), mem_req_o);
                check("tag", exp_fetch_tag(1'b0), mem_qos_o);
                check("fetch ready", mem_req_ready_i, fetch_req_ready_o);
                check("data ready", 0, data_req_ready_o);
            end
        end
        exception_pending_i = 1'b0;
        end_test();

        start_test("qos_off");
        qos_enable_i = 1'b0;
        for (int i = 0; i < 6; i++) begin
            drive_point();
            random_payloads();
            fetch_req_valid_i = i[0];
            data_req_valid_i = 1'b1;
            sample_point();
            check("valid", 1, mem_req_valid_o);
            check("req", i[0] ? fetch_beat() : data_beat(), mem_req_o);
            check("tag", base_qos_i, mem_qos_o);
            check("fetch ready", mem_req_ready_i && i[0], fetch_req_ready_o);
            check("data ready", mem_req_ready_i && !i[0], data_req_ready_o);
        end
        qos_enable_i = 1'b1;
        end_test();

        start_test("idle");
        drive_point();
        idle_inputs();
        random_payloads();
        sample_point();
        check("valid", 0, mem_req_valid_o);
        check("req", 0, mem_req_o);
        check("tag", 0, mem_qos_o);
        check("fetch ready", 1, fetch_req_ready_o);
        check("data ready", 1, data_req_ready_o);
        end_test();

        start_test("responses");
        for (int i = 0; i < 8; i++) begin
            drive_point();
            rnd = $urandom;
            mem_rsp_valid_i = (i != 7);
            // Every other response targets fetch
            mem_rsp_i.id = i[0] ? rnd[3:0] : `MEM_ID_FETCH;
            mem_rsp_i.rdata = $urandom;
            mem_rsp_i.error = rnd[4];
            fetch_rsp_ready_i = rnd[5];
            data_rsp_ready_i = rnd[6];
            sample_point();
            if (!mem_rsp_valid_i) begin
                check("fetch valid", 0, fetch_rsp_valid_o);
                check("data valid", 0, data_rsp_valid_o);
                check("mem ready", 1, mem_rsp_ready_o);
            end else if (mem_rsp_i.id == `MEM_ID_FETCH) begin
                check("fetch valid", 1, fetch_rsp_valid_o);
                check("fetch rsp", mem_rsp_i, fetch_rsp_o);
                check("data valid", 0, data_rsp_valid_o);
                check("data rsp", 0, data_rsp_o);
                check("mem ready", fetch_rsp_ready_i, mem_rsp_ready_o);
            end else begin
                check("data valid", 1, data_rsp_valid_o);
                check("data rsp", mem_rsp_i, data_rsp_o);
                check("fetch valid", 0, fetch_rsp_valid_o);
                check("fetch rsp", 0, fetch_rsp_o);
                check("mem ready", data_rsp_ready_i, mem_rsp_ready_o);
            end
        end
        end_test();

        $display("Tests: %0d passed, %0d failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule : tb_core_mem_port

`default_nettype wire

// File: core_mem_port.f
+incdir+hw
hw/mem_qos_pkg.sv
hw/mem_qos_policy.sv
hw/mem_req_arbiter.sv
hw/mem_rsp_router.sv
hw/core_mem_port.sv
bench/tb_core_mem_port.sv

// File: hw/core_mem_port.sv
// Core memory port: QoS tag policy, request arbiter, response router
`timescale 1ns/1ps
`default_nettype none

`include "mem_qos_macros.svh"

module core_mem_port
    import mem_qos_pkg::*;
#(
    // Core number, 0 to 15
    parameter int unsigned CORE_ID = 0
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,

    // ------------------------------
    // QoS control
    // ------------------------------
    input  logic                   qos_enable_i,
    input  logic                   exception_pending_i,
    input  qos_tag_t               base_qos_i,
    output logic [`QOS_VIOL_W-1:0] qos_violations_o,

    // ------------------------------
    // Requesters
    // ------------------------------
    input  logic                   fetch_req_valid_i,
    input  logic [`MEM_ADDR_W-1:0] fetch_req_addr_i,
    output logic                   fetch_req_ready_o,
    input  logic                   data_req_valid_i,
    input  logic                   data_req_write_i,
    input  logic [`MEM_ADDR_W-1:0] data_req_addr_i,
    input  logic [`MEM_STRB_W-1:0] data_req_strb_i,
    input  logic [`MEM_DATA_W-1:0] data_req_wdata_i,
    output logic                   data_req_ready_o,

    // ------------------------------
    // Memory side
    // ------------------------------
    output logic                   mem_req_valid_o,
    output mem_req_t               mem_req_o,
    output qos_tag_t               mem_qos_o,
    input  logic                   mem_req_ready_i,
    input  logic                   mem_rsp_valid_i,
    input  mem_rsp_t               mem_rsp_i,
    output logic                   mem_rsp_ready_o,

    // Responses back to the requesters
    output logic                   fetch_rsp_valid_o,
    output mem_rsp_t               fetch_rsp_o,
    input  logic                   fetch_rsp_ready_i,
    output logic                   data_rsp_valid_o,
    output mem_rsp_t               data_rsp_o,
    input  logic                   data_rsp_ready_i
);

    // Tags from policy to arbiter
    qos_tag_t fetch_tag;
    qos_tag_t data_tag;

    // Write bit picks store or load tag
    mem_qos_policy #(
        .CORE_ID (CORE_ID)
    ) u_policy (
        .exception_pending_i (exception_pending_i),
        .data_write_i        (data_req_write_i),
        .fetch_tag_o         (fetch_tag),
        .data_tag_o          (data_tag)
    );

    mem_req_arbiter u_arbiter (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .qos_enable_i      (qos_enable_i),
        .fetch_tag_i       (fetch_tag),
        .data_tag_i        (data_tag),
        .base_tag_i        (base_qos_i),
        .fetch_req_valid_i (fetch_req_valid_i),
        .fetch_req_addr_i  (fetch_req_addr_i),
        .fetch_req_ready_o (fetch_req_ready_o),
        .data_req_valid_i  (data_req_valid_i),
        .data_req_write_i  (data_req_write_i),
        .data_req_addr_i   (data_req_addr_i),
        .data_req_strb_i   (data_req_strb_i),
        .data_req_wdata_i  (data_req_wdata_i),
        .data_req_ready_o  (data_req_ready_o),
        .mem_req_valid_o   (mem_req_valid_o),
        .mem_req_o         (mem_req_o),
        .mem_qos_o         (mem_qos_o),
        .mem_req_ready_i   (mem_req_ready_i),
        .qos_violations_o  (qos_violations_o)
    );

    mem_rsp_router u_router (
        .mem_rsp_valid_i   (mem_rsp_valid_i),
        .mem_rsp_i         (mem_rsp_i),
        .mem_rsp_ready_o   (mem_rsp_ready_o),
        .fetch_rsp_valid_o (fetch_rsp_valid_o),
        .fetch_rsp_o       (fetch_rsp_o),
        .fetch_rsp_ready_i (fetch_rsp_ready_i),
        .data_rsp_valid_o  (data_rsp_valid_o),
        .data_rsp_o        (data_rsp_o),
        .data_rsp_ready_i  (data_rsp_ready_i)
    );

endmodule : core_mem_port

`default_nettype wire

// File: hw/mem_qos_macros.svh
// Memory port widths, fixed transaction IDs and burst length
// QoS levels, weights and latency limits for fetch and data tags
`ifndef MEM_QOS_MACROS_SVH
`define MEM_QOS_MACROS_SVH

// ------------------------------
// Request and response fields
// ------------------------------
`define MEM_ADDR_W 32
`define MEM_DATA_W 32
`define MEM_STRB_W 4
`define MEM_ID_W 4
`define MEM_BURST_W 3

// One ID per requester, responses are routed on it
`define MEM_ID_FETCH 4'd0
`define MEM_ID_DATA 4'd1

// Fetches always read a whole word
`define MEM_STRB_FULL 4'hF
// Single beat only
`define MEM_BURST_SINGLE 3'd0

// ------------------------------
// QoS tag fields
// ------------------------------
`define QOS_LEVEL_W 3
`define QOS_WEIGHT_W 4
`define QOS_LAT_W 8
`define QOS_CORE_W 4
`define QOS_VIOL_W 32

// Priority levels, higher wins
`define QOS_LEVEL_CRITICAL 3'd7
`define QOS_LEVEL_HIGH 3'd5
`define QOS_LEVEL_MEDIUM_HIGH 3'd4
`define QOS_LEVEL_MEDIUM 3'd3

// Bandwidth weights
`define QOS_WEIGHT_CRITICAL 4'd15
`define QOS_WEIGHT_HIGH 4'd12
`define QOS_WEIGHT_MEDIUM_HIGH 4'd8
`define QOS_WEIGHT_MEDIUM 4'd6

// Latency limits in cycles
`define QOS_LAT_FETCH_CRIT 8'd4
`define QOS_LAT_FETCH_NORM 8'd16
`define QOS_LAT_DATA_CRIT 8'd8
`define QOS_LAT_LOAD_NORM 8'd32
`define QOS_LAT_STORE_NORM 8'd64

`endif

// File: hw/mem_qos_pkg.sv
// Request, response and QoS tag types for the core memory port
`default_nettype none

`include "mem_qos_macros.svh"

package mem_qos_pkg;

    // ------------------------------
    // Memory request channel
    // ------------------------------

    // One beat on the shared request channel
    typedef struct packed {
        logic [`MEM_ADDR_W-1:0]  addr;
        // High for a store
        logic                    write;
        logic [`MEM_STRB_W-1:0]  strb;
        logic [`MEM_DATA_W-1:0]  wdata;
        // Selects the response target
        logic [`MEM_ID_W-1:0]    id;
        logic [`MEM_BURST_W-1:0] burst_len;
    } mem_req_t;

    // ------------------------------
    // Memory response channel
    // ------------------------------

    typedef struct packed {
        logic [`MEM_ID_W-1:0]   id;
        logic [`MEM_DATA_W-1:0] rdata;
        // Bus error on this access
        logic                   error;
    } mem_rsp_t;

    // ------------------------------
    // QoS tag
    // ------------------------------

    // Travels next to each request to the system arbiter
    typedef struct packed {
        logic [`QOS_LEVEL_W-1:0]  level;
        // Set for instruction fetches
        logic                     fetch_not_data;
        // Tie-break between equal levels
        logic                     urgent;
        logic                     guaranteed_bw;
        logic [`QOS_WEIGHT_W-1:0] weight;
        // Deadline in cycles
        logic [`QOS_LAT_W-1:0]    max_latency;
        logic [`QOS_CORE_W-1:0]   core_id;
        logic                     preemptable;
        logic                     real_time;
    } qos_tag_t;

endpackage : mem_qos_pkg

`default_nettype wire

// File: hw/mem_qos_policy.sv
// QoS tag policy for instruction fetches and data accesses
`timescale 1ns/1ps
`default_nettype none

`include "mem_qos_macros.svh"

module mem_qos_policy
    import mem_qos_pkg::*;
#(
    parameter int unsigned CORE_ID = 0
) (
    // Any pipeline stage holds an exception
    input  logic     exception_pending_i,
    // Write bit of the pending data request
    input  logic     data_write_i,
    output qos_tag_t fetch_tag_o,
    output qos_tag_t data_tag_o
);

    // Core number as carried in the tag
    localparam logic [`QOS_CORE_W-1:0] CORE_TAG = CORE_ID[`QOS_CORE_W-1:0];

    // ------------------------------
    // Fetch tag
    // ------------------------------

    always_comb begin : proc_fetch_tag
        fetch_tag_o                = '0;
        fetch_tag_o.fetch_not_data = 1'b1;
        // Fetches always reserve bandwidth
        fetch_tag_o.guaranteed_bw  = 1'b1;
        fetch_tag_o.core_id        = CORE_TAG;
        if (exception_pending_i) begin
            // Handler fetch must not wait
            fetch_tag_o.level       = `QOS_LEVEL_CRITICAL;
            fetch_tag_o.weight      = `QOS_WEIGHT_CRITICAL;
            fetch_tag_o.max_latency = `QOS_LAT_FETCH_CRIT;
            fetch_tag_o.urgent      = 1'b1;
            fetch_tag_o.real_time   = 1'b1;
            fetch_tag_o.preemptable = 1'b0;
        end else begin
            fetch_tag_o.level       = `QOS_LEVEL_HIGH;
            fetch_tag_o.weight      = `QOS_WEIGHT_HIGH;
            fetch_tag_o.max_latency = `QOS_LAT_FETCH_NORM;
            fetch_tag_o.urgent      = 1'b0;
            fetch_tag_o.real_time   = 1'b0;
            fetch_tag_o.preemptable = 1'b1;
        end
    end

    // ------------------------------
    // Data tag
    // ------------------------------

    always_comb begin : proc_data_tag
        data_tag_o                = '0;
        data_tag_o.fetch_not_data = 1'b0;
        data_tag_o.core_id        = CORE_TAG;
        if (exception_pending_i) begin
            // Exception outranks the fetch stream too
            data_tag_o.level         = `QOS_LEVEL_CRITICAL;
            data_tag_o.weight        = `QOS_WEIGHT_CRITICAL;
            data_tag_o.max_latency   = `QOS_LAT_DATA_CRIT;
            data_tag_o.urgent        = 1'b1;
            data_tag_o.real_time     = 1'b1;
            data_tag_o.preemptable   = 1'b0;
            data_tag_o.guaranteed_bw = 1'b1;
        end else begin
            data_tag_o.urgent        = 1'b0;
            data_tag_o.real_time     = 1'b0;
            data_tag_o.preemptable   = 1'b1;
            data_tag_o.guaranteed_bw = 1'b0;
            if (data_write_i) begin
                // Stores can be buffered, lowest level
                data_tag_o.level       = `QOS_LEVEL_MEDIUM;
                data_tag_o.weight      = `QOS_WEIGHT_MEDIUM;
                data_tag_o.max_latency = `QOS_LAT_STORE_NORM;
            end else begin
                data_tag_o.level       = `QOS_LEVEL_MEDIUM_HIGH;
                data_tag_o.weight      = `QOS_WEIGHT_MEDIUM_HIGH;
                data_tag_o.max_latency = `QOS_LAT_LOAD_NORM;
            end
        end
    end

endmodule : mem_qos_policy

`default_nettype wire

// File: hw/mem_req_arbiter.sv
// Fetch/data arbiter for the shared memory request channel
// Also counts cycles stalled by memory back-pressure
`timescale 1ns/1ps
`default_nettype none

`include "mem_qos_macros.svh"

module mem_req_arbiter
    import mem_qos_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   qos_enable_i,
    input  qos_tag_t               fetch_tag_i,
    input  qos_tag_t               data_tag_i,
    // Tag sent while QoS is off
    input  qos_tag_t               base_tag_i,
    // Fetch requester
    input  logic                   fetch_req_valid_i,
    input  logic [`MEM_ADDR_W-1:0] fetch_req_addr_i,
    output logic                   fetch_req_ready_o,
    // Data requester
    input  logic                   data_req_valid_i,
    input  logic                   data_req_write_i,
    input  logic [`MEM_ADDR_W-1:0] data_req_addr_i,
    input  logic [`MEM_STRB_W-1:0] data_req_strb_i,
    input  logic [`MEM_DATA_W-1:0] data_req_wdata_i,
    output logic                   data_req_ready_o,
    // Shared channel
    output logic                   mem_req_valid_o,
    output mem_req_t               mem_req_o,
    output qos_tag_t               mem_qos_o,
    input  logic                   mem_req_ready_i,
    output logic [`QOS_VIOL_W-1:0] qos_violations_o
);

    mem_req_t               fetch_req;
    mem_req_t               data_req;
    logic                   fetch_wins;
    logic                   stalled;
    logic [`QOS_VIOL_W-1:0] viol_cnt_q;

    // ------------------------------
    // Request beats
    // ------------------------------

    // Fetch is a single-word read
    always_comb begin : proc_fetch_req
        fetch_req.addr      = fetch_req_addr_i;
        fetch_req.write     = 1'b0;
        fetch_req.strb      = `MEM_STRB_FULL;
        fetch_req.wdata     = '0;
        fetch_req.id        = `MEM_ID_FETCH;
        fetch_req.burst_len = `MEM_BURST_SINGLE;
    end

    always_comb begin : proc_data_req
        data_req.addr      = data_req_addr_i;
        data_req.write     = data_req_write_i;
        data_req.strb      = data_req_strb_i;
        data_req.wdata     = data_req_wdata_i;
        data_req.id        = `MEM_ID_DATA;
        data_req.burst_len = `MEM_BURST_SINGLE;
    end

    // ------------------------------
    // Winner select
    // ------------------------------

    always_comb begin : proc_fetch_wins
        fetch_wins = 1'b0;
        if (fetch_req_valid_i && data_req_valid_i) begin
            if (fetch_tag_i.level > data_tag_i.level) begin
                fetch_wins = 1'b1;
            end else if (fetch_tag_i.level == data_tag_i.level) begin
                // Urgency breaks a tie, data otherwise
                fetch_wins = fetch_tag_i.urgent && !data_tag_i.urgent;
            end
        end else if (fetch_req_valid_i) begin
            fetch_wins = 1'b1;
        end
    end

    always_comb begin : proc_channel
        mem_req_valid_o   = 1'b0;
        mem_req_o         = '0;
        mem_qos_o         = '0;
        fetch_req_ready_o = 1'b0;
        data_req_ready_o  = 1'b0;
        if (qos_enable_i) begin
            if (fetch_wins) begin
                mem_req_valid_o   = 1'b1;
                mem_req_o         = fetch_req;
                mem_qos_o         = fetch_tag_i;
                fetch_req_ready_o = mem_req_ready_i;
            end else if (data_req_valid_i) begin
                mem_req_valid_o  = 1'b1;
                mem_req_o        = data_req;
                mem_qos_o        = data_tag_i;
                data_req_ready_o = mem_req_ready_i;
            end else begin
                // Idle, both sides may present
                fetch_req_ready_o = 1'b1;
                data_req_ready_o  = 1'b1;
            end
        end else begin
            // Fixed priority to fetch
            mem_req_valid_o   = fetch_req_valid_i || data_req_valid_i;
            mem_req_o         = fetch_req_valid_i ? fetch_req : data_req;
            mem_qos_o         = base_tag_i;
            fetch_req_ready_o = mem_req_ready_i && fetch_req_valid_i;
            data_req_ready_o  = mem_req_ready_i && !fetch_req_valid_i;
        end
    end

    // ------------------------------
    // Violation counter
    // ------------------------------

    // Request held against back-pressure
    assign stalled = mem_req_valid_o && !mem_req_ready_i && qos_enable_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_viol_cnt
        if (!rst_ni) begin
            viol_cnt_q <= '0;
        end else if (stalled) begin
            viol_cnt_q <= viol_cnt_q + 1'b1;
        end
    end

    assign qos_violations_o = viol_cnt_q;

endmodule : mem_req_arbiter

`default_nettype wire

// File: hw/mem_rsp_router.sv
// Response router from the memory channel to fetch or data by ID
`timescale 1ns/1ps
`default_nettype none

`include "mem_qos_macros.svh"

module mem_rsp_router
    import mem_qos_pkg::*;
(
    input  logic     mem_rsp_valid_i,
    input  mem_rsp_t mem_rsp_i,
    output logic     mem_rsp_ready_o,
    // Fetch side
    output logic     fetch_rsp_valid_o,
    output mem_rsp_t fetch_rsp_o,
    input  logic     fetch_rsp_ready_i,
    // Data side
    output logic     data_rsp_valid_o,
    output mem_rsp_t data_rsp_o,
    input  logic     data_rsp_ready_i
);

    logic to_fetch;

    // Fetch owns one ID, everything else is data
    assign to_fetch = (mem_rsp_i.id == `MEM_ID_FETCH);

    always_comb begin : proc_route
        fetch_rsp_valid_o = 1'b0;
        fetch_rsp_o       = '0;
        data_rsp_valid_o  = 1'b0;
        data_rsp_o        = '0;
        // Nothing to take, so always accept
        mem_rsp_ready_o   = 1'b1;
        if (mem_rsp_valid_i) begin
            if (to_fetch) begin
                fetch_rsp_valid_o = 1'b1;
                fetch_rsp_o       = mem_rsp_i;
                mem_rsp_ready_o   = fetch_rsp_ready_i;
            end else begin
                data_rsp_valid_o = 1'b1;
                data_rsp_o       = mem_rsp_i;
                mem_rsp_ready_o  = data_rsp_ready_i;
            end
        end
    end

endmodule : mem_rsp_router

`default_nettype wire
